/* verilog.f */
common/isa_pkg.sv
common/datapath_pkg.sv
control/instr_decoder.sv
control/main_fsm.sv
control/ctrl_word_gen.sv
hdl/control_unit.sv
dv/ctrl_checker.sv
dv/control_unit_tb.sv

/* dv/control_unit_tb.sv */
`timescale 1ns/1ps

module control_unit_tb;

    typedef struct {
        isa_pkg::instr_t          word;
        datapath_pkg::alu_flags_t flags;
        isa_pkg::instr_class_t    cls;
        logic [3:0]               sel;
        logic                     trap;
        logic                     taken;
        datapath_pkg::alu_op_t    op;
        int                       cycles;
    } row_t;

    logic                     CLK;
    logic                     RST;
    isa_pkg::instr_t          instr;
    datapath_pkg::alu_flags_t flags;
    datapath_pkg::ctrl_word_t ctrl;
    logic                     fetch;

    row_t        rows[$];
    row_t        cur;
    int          row_idx;
    int          applied;
    int          cycle_count;
    int          limit;
    logic        all_applied;
    logic [15:0] lfsr;

    control_unit dut_i (
        .CLK   (CLK),
        .RST   (RST),
        .instr (instr),
        .flags (flags),
        .ctrl  (ctrl)
    );

    ctrl_checker chk_i (
        .CLK        (CLK),
        .RST        (RST),
        .ctrl       (ctrl),
        .row_idx    (row_idx),
        .exp_cls    (cur.cls),
        .exp_sel    (cur.sel),
        .exp_trap   (cur.trap),
        .exp_taken  (cur.taken),
        .exp_op     (cur.op),
        .exp_cycles (cur.cycles),
        .fetch      (fetch)
    );

    always #4 CLK = ~CLK;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    task automatic push_row(input isa_pkg::instr_t w, input logic [2:0] f,
                            input isa_pkg::instr_class_t c, input logic [3:0] sel,
                            input logic trap, input logic taken,
                            input datapath_pkg::alu_op_t op, input int cycles);
        row_t r;
        r.word   = w;
        r.flags  = f;
        r.cls    = c;
        r.sel    = sel;
        r.trap   = trap;
        r.taken  = taken;
        r.op     = op;
        r.cycles = cycles;
        rows.push_back(r);
    endtask

    // Flags are {zero, less, overflow}
    task automatic alu_row(input isa_pkg::instr_t w, input logic [2:0] f,
                           input isa_pkg::instr_class_t c, input datapath_pkg::alu_op_t op);
        logic [3:0] wb;
        if (c == isa_pkg::cls_upper) begin
            wb = datapath_pkg::wb_lui_imm;
        end else if (op == datapath_pkg::alu_slt) begin
            wb = f[1] ? datapath_pkg::wb_one : datapath_pkg::wb_zero;
        end else begin
            wb = datapath_pkg::wb_alu_out;
        end
        push_row(w, f, c, wb, 1'b0, 1'b0, op, 5);
    endtask

    task automatic load_row(input isa_pkg::instr_t w, input logic [3:0] wb);
        push_row(w, 3'b000, isa_pkg::cls_load, wb, 1'b0, 1'b0, datapath_pkg::alu_add, 7);
    endtask

    task automatic store_row(input isa_pkg::instr_t w, input logic [3:0] size);
        push_row(w, 3'b000, isa_pkg::cls_store, size, 1'b0, 1'b0, datapath_pkg::alu_add, 7);
    endtask

    task automatic trap_row(input isa_pkg::instr_t w, input logic [2:0] f,
                            input isa_pkg::instr_class_t c, input logic [3:0] vec);
        push_row(w, f, c, vec, 1'b1, 1'b0, datapath_pkg::alu_sub, 5);
    endtask

    task automatic branch_row(input isa_pkg::instr_t w);
        logic zero;
        logic less;
        logic taken;
        zero = lfsr_step();
        less = lfsr_step();
        case (w[14:12])
            3'b000:  taken = zero;     // beq
            3'b001:  taken = !zero;    // bne
            3'b100:  taken = less;     // blt
            default: taken = !less;    // bge
        endcase
        push_row(w, {zero, less, 1'b0}, isa_pkg::cls_branch, 4'd0, 1'b0, taken,
                 datapath_pkg::alu_none, 4);
    endtask

    task automatic fill_table();
        alu_row(32'h002081B3, 3'b000, isa_pkg::cls_alu_reg, datapath_pkg::alu_add);
        alu_row(32'h402081B3, 3'b000, isa_pkg::cls_alu_reg, datapath_pkg::alu_sub);
        alu_row(32'h0020F1B3, 3'b000, isa_pkg::cls_alu_reg, datapath_pkg::alu_and);
        alu_row(32'h00508193, 3'b000, isa_pkg::cls_alu_imm, datapath_pkg::alu_add);
        alu_row(32'h0020A1B3, 3'b010, isa_pkg::cls_alu_reg, datapath_pkg::alu_slt);
        alu_row(32'h0050A193, 3'b000, isa_pkg::cls_alu_imm, datapath_pkg::alu_slt);
        alu_row(32'h0020F1B3, 3'b001, isa_pkg::cls_alu_reg,
                datapath_pkg::alu_and);   // No trap for and
        alu_row(32'h123451B7, 3'b000, isa_pkg::cls_upper, datapath_pkg::alu_none);
        push_row(32'h00000013, 3'b000, isa_pkg::cls_nop, 4'd0, 1'b0, 1'b0,
                 datapath_pkg::alu_none, 4);
        load_row(32'h0080B183, datapath_pkg::wb_ld);
        load_row(32'h00808183, datapath_pkg::wb_lb);
        load_row(32'h00809183, datapath_pkg::wb_lh);
        load_row(32'h0080A183, datapath_pkg::wb_lw);
        load_row(32'h0080C183, datapath_pkg::wb_lbu);
        load_row(32'h0080D183, datapath_pkg::wb_lhu);
        load_row(32'h0080E183, datapath_pkg::wb_lwu);
        store_row(32'h0020B423, datapath_pkg::size_double);
        store_row(32'h0020A423, datapath_pkg::size_word);
        store_row(32'h00209423, datapath_pkg::size_half);
        store_row(32'h00208423, datapath_pkg::size_byte);
        // Each kind meets both outcomes for seed 75
        branch_row(32'h00208863);   // beq
        branch_row(32'h0020C863);   // blt
        branch_row(32'h00208863);
        branch_row(32'h00209863);   // bne
        branch_row(32'h0020C863);
        branch_row(32'h00209863);
        branch_row(32'h0020D863);   // bge
        branch_row(32'h0020D863);
        trap_row(32'hFFFFFFFF, 3'b000, isa_pkg::cls_illegal, datapath_pkg::addr_illegal_vector);
        trap_row(32'h002081B3, 3'b001, isa_pkg::cls_alu_reg, datapath_pkg::addr_overflow_vector);
        trap_row(32'h402081B3, 3'b001, isa_pkg::cls_alu_reg, datapath_pkg::addr_overflow_vector);
        trap_row(32'h00508193, 3'b001, isa_pkg::cls_alu_imm, datapath_pkg::addr_overflow_vector);
        push_row(32'h00100073, 3'b000, isa_pkg::cls_brk, 4'd0, 1'b0, 1'b0,
                 datapath_pkg::alu_none, 0);   // ebreak, last row
    endtask

    task automatic end_run();
        int total_errs;
        if (!all_applied) begin
            $display("Timeout: run stopped after %0d cycles with %0d of %0d rows applied",
                     cycle_count, applied, rows.size());
            $display("STATUS: FAIL");
        end else begin
            chk_i.close_run(total_errs);
            if (total_errs == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    endtask

    initial begin
        CLK         = 1'b0;
        RST         = 1'b1;
        instr       = '0;
        flags       = '0;
        row_idx     = 0;
        applied     = 0;
        cycle_count = 0;
        all_applied = 1'b0;
        lfsr        = 16'd75;
        fill_table();
        cur   = rows[0];
        limit = rows.size() * 8 + 20;
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(negedge CLK);
            while (!fetch) @(negedge CLK);
            cur     = rows[i];
            row_idx = i;
            instr   = cur.word;
            flags   = cur.flags;
            applied = i + 1;
        end
        all_applied = 1'b1;
    end

    // Break halts the machine, so the run always ends here
    always @(negedge CLK) begin
        cycle_count++;
        if (cycle_count >= limit) begin
            end_run();
        end
    end

endmodule

/* dv/ctrl_checker.sv */
`timescale 1ns/1ps

module ctrl_checker (
    input  logic                     CLK,
    input  logic                     RST,
    input  datapath_pkg::ctrl_word_t ctrl,
    input  int                       row_idx,
    input  isa_pkg::instr_class_t    exp_cls,
    input  logic [3:0]               exp_sel,
    input  logic                     exp_trap,
    input  logic                     exp_taken,
    input  datapath_pkg::alu_op_t    exp_op,
    input  int                       exp_cycles,
    output logic                     fetch
);

    int                    err_count = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    errs_at_start = 0;
    int                    since_rst = 0;
    int                    cyc = 0;
    int                    n_reg = 0;
    int                    n_mem = 0;
    logic                  active = 1'b0;
    logic                  fetched_once = 1'b0;
    int                    cur_row;
    int                    cur_cycles;
    isa_pkg::instr_class_t cur_cls;
    logic [3:0]            cur_sel;
    logic                  cur_trap;
    logic                  cur_taken;
    datapath_pkg::alu_op_t cur_op;

    assign fetch = ctrl.load_ir;

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic close_test(input string name);
        if (err_count == errs_at_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail", name);
        end
    endtask

    // Expected values stay latched, the testbench moves on at the next fetch
    task automatic start_row();
        active        = 1'b1;
        cyc           = 0;
        n_reg         = 0;
        n_mem         = 0;
        errs_at_start = err_count;
        cur_row       = row_idx;
        cur_cycles    = exp_cycles;
        cur_cls       = exp_cls;
        cur_sel       = exp_sel;
        cur_trap      = exp_trap;
        cur_taken     = exp_taken;
        cur_op        = exp_op;
    endtask

    task automatic check_step();
        datapath_pkg::src_b_sel_t exp_b;
        exp_b = (cur_cls == isa_pkg::cls_alu_imm) ? datapath_pkg::b_imm
                                                  : datapath_pkg::b_reg;   // Immediate form
        if (ctrl.write_reg) begin
            n_reg++;
            if (cyc != cur_cycles - 2 || ctrl.wb_sel != cur_sel) begin
                report_mismatch($sformatf(
                    "row %0d: write_reg at cycle %0d wb_sel %0d, expected %0d/%0d",
                    cur_row, cyc, ctrl.wb_sel, cur_cycles - 2, cur_sel));
            end
        end
        if (ctrl.write_mem) begin
            n_mem++;
            if (cyc != cur_cycles - 2 || ctrl.store_size != cur_sel[1:0]) begin
                report_mismatch($sformatf(
                    "row %0d: write_mem at cycle %0d size %0d, expected %0d/%0d",
                    cur_row, cyc, ctrl.store_size, cur_cycles - 2, cur_sel));
            end
        end
        if (cyc == 1 && !(ctrl.write_ab && ctrl.write_alu_out)) begin
            report_mismatch($sformatf(
                "row %0d: decode without write_ab and write_alu_out", cur_row));
        end
        if (cyc == 2) begin
            if (cur_trap) begin
                if (!ctrl.write_epc || !ctrl.write_mdr ||
                    ctrl.mem_addr_sel != cur_sel[1:0]) begin
                    report_mismatch($sformatf(
                        "row %0d: execute write_epc %0b write_mdr %0b vector %0d, expected 1/1/%0d",
                        cur_row, ctrl.write_epc, ctrl.write_mdr, ctrl.mem_addr_sel, cur_sel));
                end
            end else if (cur_cls == isa_pkg::cls_branch) begin
                if (ctrl.write_pc != cur_taken ||
                    (cur_taken && ctrl.pc_src != datapath_pkg::pc_alu_out)) begin
                    report_mismatch($sformatf("row %0d: branch write_pc %0b, expected %0b",
                                              cur_row, ctrl.write_pc, cur_taken));
                end
            end else if (cur_cls == isa_pkg::cls_alu_reg || cur_cls == isa_pkg::cls_alu_imm) begin
                if (ctrl.alu_op != cur_op || ctrl.src_a != datapath_pkg::a_reg ||
                    ctrl.src_b != exp_b) begin
                    report_mismatch($sformatf(
                        "row %0d: alu_op %0d src %0d/%0d, expected %0d/%0d/%0d",
                        cur_row, ctrl.alu_op, ctrl.src_a, ctrl.src_b,
                        cur_op, datapath_pkg::a_reg, exp_b));
                end
            end
        end
        if (cyc == 3 && cur_trap &&
            !(ctrl.write_pc && ctrl.pc_src == datapath_pkg::pc_trap_vector)) begin
            report_mismatch($sformatf(
                "row %0d: trap state without write_pc from vector", cur_row));
        end
    endtask

    task automatic finish_row(input logic halted);
        logic reg_exp;
        logic mem_exp;
        reg_exp = !cur_trap && (cur_cls == isa_pkg::cls_alu_reg ||
                                cur_cls == isa_pkg::cls_alu_imm ||
                                cur_cls == isa_pkg::cls_upper ||
                                cur_cls == isa_pkg::cls_load);
        mem_exp = !cur_trap && cur_cls == isa_pkg::cls_store;
        if (cur_cls == isa_pkg::cls_brk) begin
            if (!halted) begin
                report_mismatch($sformatf("row %0d: load_ir rose again after break", cur_row));
            end
        end else if (halted) begin
            report_mismatch($sformatf("row %0d: no fetch followed this instruction", cur_row));
        end else if (cyc + 1 != cur_cycles) begin
            report_mismatch($sformatf("row %0d: %0d cycles fetch to fetch, expected %0d",
                                      cur_row, cyc + 1, cur_cycles));
        end
        if (n_reg != reg_exp || n_mem != mem_exp) begin
            report_mismatch($sformatf(
                "row %0d: %0d register and %0d memory writes, expected %0d/%0d",
                cur_row, n_reg, n_mem, reg_exp, mem_exp));
        end
        close_test($sformatf("row %0d %s", cur_row, cur_cls.name()));
        active = 1'b0;
    endtask

    task automatic close_run(output int total);
        if (!fetched_once) begin
            report_mismatch("no fetch was seen after reset");
        end
        if (active) begin
            finish_row(1'b1);   // Halted row ends here
        end
        $display("tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        total = err_count;
    endtask

    always @(posedge CLK) begin
        if (RST) begin
            since_rst = 0;
            if (!ctrl.clear || {ctrl.load_ir, ctrl.write_pc, ctrl.write_ab,
                                ctrl.write_alu_out, ctrl.write_mdr, ctrl.write_mem,
                                ctrl.write_reg, ctrl.write_epc} != 8'd0) begin
                report_mismatch("reset: clear low or a write strobe high");
            end
        end else begin
            since_rst++;
            if (ctrl.load_ir) begin
                if (!fetched_once) begin
                    // Fetch entered on the second edge, seen on the third
                    if (since_rst != 3) begin
                        report_mismatch($sformatf(
                            "reset: first fetch seen %0d edges after release, expected 3",
                            since_rst));
                    end
                    close_test("reset");
                    fetched_once = 1'b1;
                end
                if (active) begin
                    finish_row(1'b0);
                end
                start_row();
                if (!ctrl.write_pc || ctrl.alu_op != datapath_pkg::alu_add ||
                    ctrl.src_b != datapath_pkg::b_four) begin
                    report_mismatch($sformatf("row %0d: fetch without PC + 4 update", cur_row));
                end
            end else if (active) begin
                cyc++;
                check_step();
            end
        end
    end

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic                     CLK,
    input  logic                     RST,
    input  isa_pkg::instr_t          instr,
    input  datapath_pkg::alu_flags_t flags,
    output datapath_pkg::ctrl_word_t ctrl
);

    isa_pkg::decode_t    dec;
    isa_pkg::fsm_state_t state;

    instr_decoder decoder_i (
        .instr (instr),
        .dec   (dec)
    );

    main_fsm fsm_i (
        .CLK      (CLK),
        .RST      (RST),
        .dec      (dec),
        .overflow (flags.overflow),
        .less     (flags.less),      // slt result select
        .state    (state)
    );

    ctrl_word_gen ctrl_gen_i (
        .state (state),
        .dec   (dec),
        .flags (flags),
        .ctrl  (ctrl)
    );

endmodule

/* control/ctrl_word_gen.sv */
`timescale 1ns/1ps

module ctrl_word_gen (
    input  isa_pkg::fsm_state_t      state,
    input  isa_pkg::decode_t         dec,
    input  datapath_pkg::alu_flags_t flags,
    output datapath_pkg::ctrl_word_t ctrl
);

    logic taken;
    logic ovf_trap;

    assign ovf_trap = isa_pkg::ovf_checked(dec) && flags.overflow;

    always_comb begin
        case (dec.branch_kind)
            isa_pkg::bne: taken = !flags.zero;
            isa_pkg::blt: taken = flags.less;
            isa_pkg::bge: taken = !flags.less;
            default:      taken = flags.zero;
        endcase
    end

    always_comb begin
        ctrl              = '0;
        ctrl.alu_op       = datapath_pkg::alu_none;
        ctrl.src_a        = datapath_pkg::a_pc;
        ctrl.src_b        = datapath_pkg::b_reg;
        ctrl.pc_src       = datapath_pkg::pc_alu_result;
        ctrl.mem_addr_sel = datapath_pkg::addr_alu_out;
        ctrl.wb_sel       = datapath_pkg::wb_alu_out;
        ctrl.store_size   = datapath_pkg::size_double;

        case (state)
            isa_pkg::st_reset: ctrl.clear = 1'b1;
            isa_pkg::st_fetch: begin
                ctrl.load_ir  = 1'b1;
                ctrl.write_pc = 1'b1;
                ctrl.alu_op   = datapath_pkg::alu_add;
                ctrl.src_b    = datapath_pkg::b_four;       // PC + 4
            end
            isa_pkg::st_decode: begin
                ctrl.write_ab      = 1'b1;
                ctrl.write_alu_out = 1'b1;
                ctrl.alu_op        = datapath_pkg::alu_add;
                ctrl.src_b         = datapath_pkg::b_imm_shifted;   // Branch target
            end
            isa_pkg::st_execute: begin
                ctrl.src_a = datapath_pkg::a_reg;
                case (dec.cls)
                    isa_pkg::cls_alu_reg, isa_pkg::cls_alu_imm: begin
                        ctrl.write_alu_out = 1'b1;
                        if (dec.cls == isa_pkg::cls_alu_imm) begin
                            ctrl.src_b = datapath_pkg::b_imm;
                        end
                        case (dec.fn)
                            isa_pkg::fn_sub: ctrl.alu_op = datapath_pkg::alu_sub;
                            isa_pkg::fn_and: ctrl.alu_op = datapath_pkg::alu_and;
                            isa_pkg::fn_slt: ctrl.alu_op = datapath_pkg::alu_slt;
                            default:         ctrl.alu_op = datapath_pkg::alu_add;
                        endcase
                    end
                    isa_pkg::cls_load, isa_pkg::cls_store: begin
                        ctrl.write_alu_out = 1'b1;
                        ctrl.alu_op        = datapath_pkg::alu_add;
                        ctrl.src_b         = datapath_pkg::b_imm;
                    end
                    isa_pkg::cls_branch: begin
                        ctrl.alu_op   = (dec.branch_kind == isa_pkg::bge) ?
                                        datapath_pkg::alu_ge : datapath_pkg::alu_sub;
                        ctrl.write_pc = taken;
                        ctrl.pc_src   = datapath_pkg::pc_alu_out;
                    end
                    default: ;
                endcase
                if (dec.cls == isa_pkg::cls_illegal || ovf_trap) begin
                    ctrl.write_alu_out = 1'b0;
                    ctrl.write_epc     = 1'b1;
                    ctrl.write_mdr     = 1'b1;     // Vector fetched into MDR
                    ctrl.alu_op        = datapath_pkg::alu_sub;
                    ctrl.src_a         = datapath_pkg::a_pc;
                    ctrl.src_b         = datapath_pkg::b_four;   // EPC gets PC - 4
                    ctrl.mem_addr_sel  = ovf_trap ? datapath_pkg::addr_overflow_vector :
                                                    datapath_pkg::addr_illegal_vector;
                end
            end
            isa_pkg::st_wb_alu:  ctrl.write_reg = 1'b1;
            isa_pkg::st_wb_one: begin
                ctrl.write_reg = 1'b1;
                ctrl.wb_sel    = datapath_pkg::wb_one;
            end
            isa_pkg::st_wb_zero: begin
                ctrl.write_reg = 1'b1;
                ctrl.wb_sel    = datapath_pkg::wb_zero;
            end
            isa_pkg::st_wb_lui: begin
                ctrl.write_reg = 1'b1;
                ctrl.wb_sel    = datapath_pkg::wb_lui_imm;
            end
            isa_pkg::st_load_read, isa_pkg::st_store_read: ctrl.write_mdr = 1'b1;
            isa_pkg::st_wb_load: begin
                ctrl.write_reg = 1'b1;
                case (dec.load_kind)
                    isa_pkg::lb:  ctrl.wb_sel = datapath_pkg::wb_lb;
                    isa_pkg::lh:  ctrl.wb_sel = datapath_pkg::wb_lh;
                    isa_pkg::lw:  ctrl.wb_sel = datapath_pkg::wb_lw;
                    isa_pkg::lbu: ctrl.wb_sel = datapath_pkg::wb_lbu;
                    isa_pkg::lhu: ctrl.wb_sel = datapath_pkg::wb_lhu;
                    isa_pkg::lwu: ctrl.wb_sel = datapath_pkg::wb_lwu;
                    default:      ctrl.wb_sel = datapath_pkg::wb_ld;
                endcase
            end
            isa_pkg::st_mem_write: begin
                ctrl.write_mem = 1'b1;
                case (dec.store_kind)
                    isa_pkg::sw: ctrl.store_size = datapath_pkg::size_word;
                    isa_pkg::sh: ctrl.store_size = datapath_pkg::size_half;
                    isa_pkg::sb: ctrl.store_size = datapath_pkg::size_byte;
                    default:     ctrl.store_size = datapath_pkg::size_double;
                endcase
            end
            isa_pkg::st_trap: begin
                ctrl.write_pc = 1'b1;
                ctrl.pc_src   = datapath_pkg::pc_trap_vector;
            end
            default: ;   // wait, load_wait, store_wait, halt
        endcase
    end

    // Settled values only, the word is rebuilt every delta
    always_comb begin
        a_mem_reg_excl: assert final (!(ctrl.write_mem && ctrl.write_reg));
        a_ir_with_pc:   assert final (!ctrl.load_ir || ctrl.write_pc);
    end

endmodule

/* control/main_fsm.sv */
`timescale 1ns/1ps

module main_fsm (
    input  logic                CLK,
    input  logic                RST,
    input  isa_pkg::decode_t    dec,
    input  logic                overflow,
    input  logic                less,
    output isa_pkg::fsm_state_t state
);

    isa_pkg::fsm_state_t next_state;
    logic                ovf_trap;

    assign ovf_trap = isa_pkg::ovf_checked(dec) && overflow;

    always_ff @(posedge CLK, posedge RST) begin
        if (RST) begin
            state <= isa_pkg::st_reset;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            isa_pkg::st_reset:  next_state = isa_pkg::st_wait;
            isa_pkg::st_wait:   next_state = isa_pkg::st_fetch;
            isa_pkg::st_fetch:  next_state = isa_pkg::st_decode;
            isa_pkg::st_decode: next_state = isa_pkg::st_execute;

            isa_pkg::st_execute: begin
                case (dec.cls)
                    isa_pkg::cls_alu_reg, isa_pkg::cls_alu_imm: begin
                        if (ovf_trap) begin
                            next_state = isa_pkg::st_trap;
                        end else if (dec.fn == isa_pkg::fn_slt) begin
                            // Result is a constant, picked by the compare
                            next_state = less ? isa_pkg::st_wb_one : isa_pkg::st_wb_zero;
                        end else begin
                            next_state = isa_pkg::st_wb_alu;
                        end
                    end
                    isa_pkg::cls_load:    next_state = isa_pkg::st_load_wait;
                    isa_pkg::cls_store:   next_state = isa_pkg::st_store_read;
                    isa_pkg::cls_upper:   next_state = isa_pkg::st_wb_lui;
                    isa_pkg::cls_brk:     next_state = isa_pkg::st_halt;
                    isa_pkg::cls_illegal: next_state = isa_pkg::st_trap;
                    default:              next_state = isa_pkg::st_wait;   // Branch, nop
                endcase
            end

            isa_pkg::st_wb_alu,
            isa_pkg::st_wb_one,
            isa_pkg::st_wb_zero,
            isa_pkg::st_wb_lui:     next_state = isa_pkg::st_wait;

            isa_pkg::st_load_wait:  next_state = isa_pkg::st_load_read;
            isa_pkg::st_load_read:  next_state = isa_pkg::st_wb_load;
            isa_pkg::st_wb_load:    next_state = isa_pkg::st_wait;

            isa_pkg::st_store_read: next_state = isa_pkg::st_store_wait;
            isa_pkg::st_store_wait: next_state = isa_pkg::st_mem_write;
            isa_pkg::st_mem_write:  next_state = isa_pkg::st_wait;

            isa_pkg::st_trap:       next_state = isa_pkg::st_wait;
            isa_pkg::st_halt:       next_state = isa_pkg::st_halt;   // Until reset
            default:                next_state = isa_pkg::st_reset;
        endcase
    end

    a_halt_sticky: assert property (
        @(posedge CLK) disable iff (RST)
        state == isa_pkg::st_halt |=> state == isa_pkg::st_halt
    );

endmodule

/* control/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  isa_pkg::instr_t  instr,
    output isa_pkg::decode_t dec
);

    isa_pkg::funct3_t funct3;
    logic             funct7_alt;

    assign funct3     = instr[14:12];
    assign funct7_alt = instr[30];       // Selects sub over add

    always_comb begin
        case (isa_pkg::opcode_t'(instr[6:0]))
            isa_pkg::op_alu_reg: dec.cls = isa_pkg::cls_alu_reg;
            isa_pkg::op_alu_imm: begin
                if (instr[31:7] == 25'd0) begin
                    dec.cls = isa_pkg::cls_nop;   // addi x0, x0, 0
                end else begin
                    dec.cls = isa_pkg::cls_alu_imm;
                end
            end
            isa_pkg::op_load:    dec.cls = isa_pkg::cls_load;
            isa_pkg::op_store:   dec.cls = isa_pkg::cls_store;
            isa_pkg::op_branch:  dec.cls = isa_pkg::cls_branch;
            isa_pkg::op_lui:     dec.cls = isa_pkg::cls_upper;
            isa_pkg::op_system:  dec.cls = isa_pkg::cls_brk;
            default:             dec.cls = isa_pkg::cls_illegal;
        endcase

        case (funct3)
            3'b010:  dec.fn = isa_pkg::fn_slt;
            3'b111:  dec.fn = isa_pkg::fn_and;
            default: dec.fn = isa_pkg::fn_add;
        endcase
        if (instr[6:0] == isa_pkg::op_alu_reg && funct7_alt) begin
            dec.fn = isa_pkg::fn_sub;      // Only the reg form has sub
        end

        case (funct3)
            3'b000:  dec.load_kind = isa_pkg::lb;
            3'b001:  dec.load_kind = isa_pkg::lh;
            3'b010:  dec.load_kind = isa_pkg::lw;
            3'b100:  dec.load_kind = isa_pkg::lbu;
            3'b101:  dec.load_kind = isa_pkg::lhu;
            3'b110:  dec.load_kind = isa_pkg::lwu;
            default: dec.load_kind = isa_pkg::ld;
        endcase

        case (funct3)
            3'b000:  dec.store_kind = isa_pkg::sb;
            3'b001:  dec.store_kind = isa_pkg::sh;
            3'b010:  dec.store_kind = isa_pkg::sw;
            default: dec.store_kind = isa_pkg::sd;
        endcase

        case (funct3)
            3'b001:  dec.branch_kind = isa_pkg::bne;
            3'b100:  dec.branch_kind = isa_pkg::blt;
            3'b101:  dec.branch_kind = isa_pkg::bge;
            default: dec.branch_kind = isa_pkg::beq;
        endcase
    end

endmodule

/* common/datapath_pkg.sv */
package datapath_pkg;

    typedef struct packed {
        logic zero;
        logic less;
        logic overflow;
    } alu_flags_t;

    typedef enum logic [2:0] {
        alu_none = 3'b000,
        alu_add  = 3'b001,
        alu_sub  = 3'b010,
        alu_and  = 3'b011,
        alu_ge   = 3'b101,
        alu_slt  = 3'b110
    } alu_op_t;

    typedef enum logic [1:0] {
        a_pc   = 2'b00,
        a_reg  = 2'b01,
        a_zero = 2'b11
    } src_a_sel_t;

    typedef enum logic [1:0] {
        b_reg         = 2'b00,
        b_four        = 2'b01,
        b_imm         = 2'b10,
        b_imm_shifted = 2'b11
    } src_b_sel_t;

    typedef enum logic [1:0] {
        pc_alu_out     = 2'b00,
        pc_alu_result  = 2'b01,
        pc_trap_vector = 2'b10
    } pc_src_sel_t;

    typedef enum logic [1:0] {
        addr_alu_out         = 2'b00,
        addr_illegal_vector  = 2'b01,
        addr_overflow_vector = 2'b10
    } mem_addr_sel_t;

    typedef enum logic [3:0] {
        wb_alu_out = 4'd0,
        wb_lui_imm = 4'd1,
        wb_one     = 4'd2,
        wb_zero    = 4'd3,
        wb_ld      = 4'd5,
        wb_lb      = 4'd6,
        wb_lh      = 4'd7,
        wb_lw      = 4'd8,
        wb_lbu     = 4'd9,
        wb_lhu     = 4'd10,
        wb_lwu     = 4'd11
    } wb_sel_t;

    typedef enum logic [1:0] {size_double, size_word, size_half, size_byte} store_size_t;

    typedef struct packed {
        alu_op_t       alu_op;
        src_a_sel_t    src_a;
        src_b_sel_t    src_b;
        pc_src_sel_t   pc_src;
        mem_addr_sel_t mem_addr_sel;
        wb_sel_t       wb_sel;
        store_size_t   store_size;
        logic          clear;
        logic          load_ir;
        logic          write_pc;
        logic          write_ab;
        logic          write_alu_out;
        logic          write_mdr;
        logic          write_mem;
        logic          write_reg;
        logic          write_epc;
    } ctrl_word_t;

endpackage

/* common/isa_pkg.sv */
package isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [6:0] {
        op_alu_reg = 7'b0110011,
        op_alu_imm = 7'b0010011,
        op_load    = 7'b0000011,
        op_store   = 7'b0100011,
        op_branch  = 7'b1100011,
        op_lui     = 7'b0110111,
        op_system  = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        cls_alu_reg, cls_alu_imm, cls_load, cls_store, cls_branch,
        cls_upper, cls_nop, cls_brk, cls_illegal
    } instr_class_t;

    typedef enum logic [1:0] {fn_add, fn_sub, fn_and, fn_slt} alu_fn_t;
    typedef enum logic [2:0] {ld, lb, lh, lw, lbu, lhu, lwu} load_kind_t;
    typedef enum logic [1:0] {sd, sw, sh, sb} store_kind_t;
    typedef enum logic [1:0] {beq, bne, blt, bge} branch_kind_t;

    typedef struct packed {
        instr_class_t cls;
        alu_fn_t      fn;
        load_kind_t   load_kind;
        store_kind_t  store_kind;
        branch_kind_t branch_kind;
    } decode_t;

    // Multicycle sequence, state register lives in main_fsm
    typedef enum logic [4:0] {
        st_reset, st_wait, st_fetch, st_decode, st_execute,
        st_wb_alu, st_wb_one, st_wb_zero, st_wb_lui,
        st_load_wait, st_load_read, st_wb_load,
        st_store_read, st_store_wait, st_mem_write,
        st_trap, st_halt
    } fsm_state_t;

    // add, sub and addi are the only ones that trap on overflow
    function automatic logic ovf_checked(decode_t d);
        return (d.cls == cls_alu_reg && (d.fn == fn_add || d.fn == fn_sub)) ||
               (d.cls == cls_alu_imm && d.fn == fn_add);
    endfunction

endpackage
